// ==== hdl/axiPkg.sv ====
/* AXI-side types for the bridge. Only 32-bit data and 4-byte beats are supported;
   burst encoding 2 (WRAP) is not decoded and is handled as INCR. */
package axiPkg;

  // ====================
  // widths
  // ====================
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [7:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  prot_t;

  // address step per beat
  localparam int unsigned BeatBytes = 4;

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1
  } burst_e;

  // codes grow with severity
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  // ====================
  // channel payloads
  // ====================
  // shared by AR and AW
  typedef struct packed {
    addr_t  addr;
    id_t    id;
    len_t   len;
    burst_e burst;
    prot_t  prot;
  } addrReq_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } wBeat_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
    id_t   id;
    logic  last;
  } rBeat_t;

  typedef struct packed {
    resp_e resp;
    id_t   id;
  } bRsp_t;

endpackage

// ==== hdl/apbPkg.sv ====
/* APB-side types. Address and data widths follow the AXI side of the bridge. */
package apbPkg;

  // transfer phases of the APB master
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } apbState_e;

  // ====================
  // shared request lines
  // ====================
  // psel and penable travel separately
  typedef struct packed {
    axiPkg::addr_t paddr;
    axiPkg::data_t pwdata;
    axiPkg::strb_t pstrb;
    axiPkg::prot_t pprot;
    logic          pwrite;
  } apbReq_t;

endpackage

// ==== hdl/syncFifo.sv ====
/* First-word-fall-through queue on one clock. A write shows at the output one cycle later;
   inReady drops only when full. Depth of at least 1. */
module syncFifo #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 4
) (
  input  logic             pclk,
  input  logic             preset_n,
  input  logic [Width-1:0] inData,
  input  logic             inValid,
  output logic             inReady,
  output logic [Width-1:0] outData,
  output logic             outValid,
  input  logic             outReady
);
  localparam int unsigned PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntBits = $clog2(Depth + 1);

  logic [Width-1:0]   mem [Depth];
  logic [PtrBits-1:0] wrPtr;
  logic [PtrBits-1:0] rdPtr;
  logic [CntBits-1:0] count;
  logic               push;
  logic               pop;

  assign inReady  = (count != CntBits'(Depth));
  assign outValid = (count != '0);
  assign outData  = mem[rdPtr];
  assign push     = inValid & inReady;
  assign pop      = outValid & outReady;

  always_ff @(posedge pclk) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == PtrBits'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == PtrBits'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/readPath.sv ====
/* Read command and read beat queues. A command stays at the head until the sequencer
   finishes its last beat. */
module readPath #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic             pclk,
  input  logic             preset_n,
  // AXI read channels
  input  axiPkg::addrReq_t arReq,
  input  logic             arValid,
  output logic             arReady,
  output axiPkg::rBeat_t   rBeat,
  output logic             rValid,
  input  logic             rReady,
  // toward the sequencer
  output axiPkg::addrReq_t rdCmd,
  output logic             rdCmdValid,
  input  logic             rdCmdReady,
  input  axiPkg::rBeat_t   rdBeat,
  input  logic             rdBeatValid,
  output logic             rdBeatReady
);

  // AR commands
  syncFifo #(
    .Width($bits(axiPkg::addrReq_t)),
    .Depth(FifoDepth)
  ) arFifo_i (
    .pclk    (pclk),
    .preset_n(preset_n),
    .inData  (arReq),
    .inValid (arValid),
    .inReady (arReady),
    .outData (rdCmd),
    .outValid(rdCmdValid),
    .outReady(rdCmdReady)
  );

  // R beats, ready doubles as space for one more beat
  syncFifo #(
    .Width($bits(axiPkg::rBeat_t)),
    .Depth(FifoDepth)
  ) rFifo_i (
    .pclk    (pclk),
    .preset_n(preset_n),
    .inData  (rdBeat),
    .inValid (rdBeatValid),
    .inReady (rdBeatReady),
    .outData (rBeat),
    .outValid(rValid),
    .outReady(rReady)
  );

endmodule

// ==== hdl/writePath.sv ====
/* Write command, write data and write response queues, each independent.
   wlast is not carried; burst length comes from the command. */
module writePath #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic             pclk,
  input  logic             preset_n,
  // AXI write channels
  input  axiPkg::addrReq_t awReq,
  input  logic             awValid,
  output logic             awReady,
  input  axiPkg::wBeat_t   wBeat,
  input  logic             wValid,
  output logic             wReady,
  output axiPkg::bRsp_t    bRsp,
  output logic             bValid,
  input  logic             bReady,
  // toward the sequencer
  output axiPkg::addrReq_t wrCmd,
  output logic             wrCmdValid,
  input  logic             wrCmdReady,
  output axiPkg::wBeat_t   wrData,
  output logic             wrDataValid,
  input  logic             wrDataReady,
  input  axiPkg::bRsp_t    wrRsp,
  input  logic             wrRspValid,
  output logic             wrRspReady
);

  syncFifo #(
    .Width($bits(axiPkg::addrReq_t)),
    .Depth(FifoDepth)
  ) awFifo_i (
    .pclk    (pclk),
    .preset_n(preset_n),
    .inData  (awReq),
    .inValid (awValid),
    .inReady (awReady),
    .outData (wrCmd),
    .outValid(wrCmdValid),
    .outReady(wrCmdReady)
  );

  // data may arrive ahead of its command
  syncFifo #(
    .Width($bits(axiPkg::wBeat_t)),
    .Depth(FifoDepth)
  ) wFifo_i (
    .pclk    (pclk),
    .preset_n(preset_n),
    .inData  (wBeat),
    .inValid (wValid),
    .inReady (wReady),
    .outData (wrData),
    .outValid(wrDataValid),
    .outReady(wrDataReady)
  );

  syncFifo #(
    .Width($bits(axiPkg::bRsp_t)),
    .Depth(FifoDepth)
  ) bFifo_i (
    .pclk    (pclk),
    .preset_n(preset_n),
    .inData  (wrRsp),
    .inValid (wrRspValid),
    .inReady (wrRspReady),
    .outData (bRsp),
    .outValid(bValid),
    .outReady(bReady)
  );

endmodule

// ==== hdl/apbSequencer.sv ====
/* One APB transfer at a time; the burst command stays at its queue head until the last beat.
   Slave k owns window k of 2^WinBits bytes; a burst should not cross a window. */
module apbSequencer #(
  parameter int unsigned NumSlaves = 4,
  parameter int unsigned WinBits   = 12
) (
  input  logic                           pclk,
  input  logic                           preset_n,
  // read side
  input  axiPkg::addrReq_t               rdCmd,
  input  logic                           rdCmdValid,
  output logic                           rdCmdReady,
  output axiPkg::rBeat_t                 rdBeat,
  output logic                           rdBeatValid,
  input  logic                           rdBeatReady,
  // write side
  input  axiPkg::addrReq_t               wrCmd,
  input  logic                           wrCmdValid,
  output logic                           wrCmdReady,
  input  axiPkg::wBeat_t                 wrData,
  input  logic                           wrDataValid,
  output logic                           wrDataReady,
  output axiPkg::bRsp_t                  wrRsp,
  output logic                           wrRspValid,
  input  logic                           wrRspReady,
  // APB master
  output apbPkg::apbReq_t                apbReq,
  output logic [NumSlaves-1:0]           psel,
  output logic                           penable,
  input  logic [NumSlaves-1:0]           pready,
  input  axiPkg::data_t [NumSlaves-1:0]  prdata,
  input  logic [NumSlaves-1:0]           pslverr
);
  localparam int unsigned AddrBits = $bits(axiPkg::addr_t);
  localparam int unsigned IdxBits  = AddrBits - WinBits;

  apbPkg::apbState_e    state;
  logic                 active;
  logic                 isWrite;
  logic                 lastWrite;
  logic                 pickWrite;
  axiPkg::addr_t        curAddr;
  axiPkg::len_t         beatCnt;
  axiPkg::resp_e        wrErr;
  axiPkg::addrReq_t     cmd;
  axiPkg::addrReq_t     newCmd;
  logic [IdxBits-1:0]   winIdx;
  logic [NumSlaves-1:0] slvHit;
  logic                 decErr;
  logic                 readySel;
  logic                 errSel;
  axiPkg::data_t        rdataSel;
  axiPkg::resp_e        beatResp;
  axiPkg::resp_e        burstResp;
  logic                 beatGo;
  logic                 beatDone;
  logic                 lastBeat;

  // ====================
  // read/write alternation
  // ====================
  // with both pending, serve the direction that did not go last
  assign pickWrite = wrCmdValid & (~rdCmdValid | ~lastWrite);
  assign newCmd    = pickWrite ? wrCmd : rdCmd;
  assign cmd       = isWrite ? wrCmd : rdCmd;

  // ====================
  // decode and slave return
  // ====================
  assign winIdx = curAddr[AddrBits-1:WinBits];

  always_comb begin
    for (int k = 0; k < NumSlaves; k++) begin
      slvHit[k] = (winIdx == IdxBits'(k));
    end
  end

  // no window hit means decode error, and no psel
  assign decErr   = ~|slvHit;
  assign readySel = |(pready & slvHit);
  assign errSel   = |(pslverr & slvHit);

  // stays zero on a decode error
  always_comb begin
    rdataSel = '0;
    for (int k = 0; k < NumSlaves; k++) begin
      if (slvHit[k]) begin
        rdataSel = prdata[k];
      end
    end
  end

  always_comb begin
    if (decErr) begin
      beatResp = axiPkg::DECERR;
    end else if (errSel) begin
      beatResp = axiPkg::SLVERR;
    end else begin
      beatResp = axiPkg::OKAY;
    end
  end

  // worst code seen over the write burst
  assign burstResp = (beatResp > wrErr) ? beatResp : wrErr;

  // ====================
  // beat control
  // ====================
  assign lastBeat = (beatCnt == cmd.len);
  // first write beat also reserves a slot for its B response
  assign beatGo   = isWrite ? (wrDataValid & (wrRspReady | (beatCnt != '0))) : rdBeatReady;
  assign beatDone = (state == apbPkg::ACCESS) & (decErr | readySel);

  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      state     <= apbPkg::IDLE;
      active    <= 1'b0;
      isWrite   <= 1'b0;
      lastWrite <= 1'b1;
      curAddr   <= '0;
      beatCnt   <= '0;
      wrErr     <= axiPkg::OKAY;
    end else begin
      case (state)
        apbPkg::IDLE: begin
          if (!active) begin
            if (rdCmdValid | wrCmdValid) begin
              active    <= 1'b1;
              isWrite   <= pickWrite;
              lastWrite <= pickWrite;
              curAddr   <= newCmd.addr;
              beatCnt   <= '0;
              wrErr     <= axiPkg::OKAY;
            end
          end else if (beatGo) begin
            state <= apbPkg::SETUP;
          end
        end
        apbPkg::SETUP: begin
          state <= apbPkg::ACCESS;
        end
        apbPkg::ACCESS: begin
          if (beatDone) begin
            state <= apbPkg::IDLE;
            wrErr <= burstResp;
            if (lastBeat) begin
              active <= 1'b0;
            end else begin
              beatCnt <= beatCnt + 1'b1;
              // FIXED holds the address, anything else steps
              if (cmd.burst != axiPkg::FIXED) begin
                curAddr <= curAddr + axiPkg::addr_t'(axiPkg::BeatBytes);
              end
            end
          end
        end
        default: begin
          state <= apbPkg::IDLE;
        end
      endcase
    end
  end

  // ====================
  // outputs
  // ====================
  assign psel    = (state == apbPkg::IDLE) ? '0 : slvHit;
  assign penable = (state == apbPkg::ACCESS);

  always_comb begin
    apbReq.paddr  = curAddr;
    apbReq.pwdata = isWrite ? wrData.data : '0;
    apbReq.pstrb  = isWrite ? wrData.strb : '0;
    apbReq.pprot  = cmd.prot;
    apbReq.pwrite = isWrite;
  end

  assign rdBeatValid = beatDone & ~isWrite;
  assign rdCmdReady  = beatDone & ~isWrite & lastBeat;
  assign wrDataReady = beatDone & isWrite;
  assign wrCmdReady  = beatDone & isWrite & lastBeat;
  assign wrRspValid  = beatDone & isWrite & lastBeat;

  always_comb begin
    rdBeat.data = rdataSel;
    rdBeat.resp = beatResp;
    rdBeat.id   = rdCmd.id;
    rdBeat.last = lastBeat;
    wrRsp.resp  = burstResp;
    wrRsp.id    = wrCmd.id;
  end

endmodule

// ==== hdl/axiApbBridge.sv ====
/* AXI to APB bridge on a single clock. Handles FIXED and INCR bursts of 4-byte beats;
   addresses at or above NumSlaves windows answer DECERR. */
module axiApbBridge #(
  parameter int unsigned NumSlaves = 4,
  parameter int unsigned WinBits   = 12,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                           pclk,
  input  logic                           preset_n,
  // AXI
  input  axiPkg::addrReq_t               arReq,
  input  logic                           arValid,
  output logic                           arReady,
  input  axiPkg::addrReq_t               awReq,
  input  logic                           awValid,
  output logic                           awReady,
  input  axiPkg::wBeat_t                 wBeat,
  input  logic                           wValid,
  output logic                           wReady,
  output axiPkg::rBeat_t                 rBeat,
  output logic                           rValid,
  input  logic                           rReady,
  output axiPkg::bRsp_t                  bRsp,
  output logic                           bValid,
  input  logic                           bReady,
  // APB
  output apbPkg::apbReq_t                apbReq,
  output logic [NumSlaves-1:0]           psel,
  output logic                           penable,
  input  logic [NumSlaves-1:0]           pready,
  input  axiPkg::data_t [NumSlaves-1:0]  prdata,
  input  logic [NumSlaves-1:0]           pslverr
);
  axiPkg::addrReq_t rdCmd;
  logic             rdCmdValid;
  logic             rdCmdReady;
  axiPkg::rBeat_t   rdBeat;
  logic             rdBeatValid;
  logic             rdBeatReady;
  axiPkg::addrReq_t wrCmd;
  logic             wrCmdValid;
  logic             wrCmdReady;
  axiPkg::wBeat_t   wrData;
  logic             wrDataValid;
  logic             wrDataReady;
  axiPkg::bRsp_t    wrRsp;
  logic             wrRspValid;
  logic             wrRspReady;

  readPath #(.FifoDepth(FifoDepth)) readPath_i (
    .pclk, .preset_n,
    .arReq, .arValid, .arReady,
    .rBeat, .rValid, .rReady,
    .rdCmd, .rdCmdValid, .rdCmdReady,
    .rdBeat, .rdBeatValid, .rdBeatReady
  );

  writePath #(.FifoDepth(FifoDepth)) writePath_i (
    .pclk, .preset_n,
    .awReq, .awValid, .awReady,
    .wBeat, .wValid, .wReady,
    .bRsp, .bValid, .bReady,
    .wrCmd, .wrCmdValid, .wrCmdReady,
    .wrData, .wrDataValid, .wrDataReady,
    .wrRsp, .wrRspValid, .wrRspReady
  );

  // shared APB master for both directions
  apbSequencer #(
    .NumSlaves(NumSlaves),
    .WinBits  (WinBits)
  ) apbSequencer_i (
    .pclk, .preset_n,
    .rdCmd, .rdCmdValid, .rdCmdReady,
    .rdBeat, .rdBeatValid, .rdBeatReady,
    .wrCmd, .wrCmdValid, .wrCmdReady,
    .wrData, .wrDataValid, .wrDataReady,
    .wrRsp, .wrRspValid, .wrRspReady,
    .apbReq, .psel, .penable,
    .pready, .prdata, .pslverr
  );

endmodule

// ==== dv/apbMemSlave.sv ====
/* APB memory slave model. Storage lives in the testbench top; 0 to 3 wait states per transfer,
   and words whose paddr bits 7:2 are all ones answer PSLVERR. */
module apbMemSlave (
  input  logic            pclk,
  input  logic            preset_n,
  input  logic            psel,
  input  logic            penable,
  input  apbPkg::apbReq_t apbReq,
  input  logic [1:0]      waitCycles,
  input  axiPkg::data_t   memRdata,
  output logic            pready,
  output axiPkg::data_t   prdata,
  output logic            pslverr,
  output logic            memWrite
);
  logic [1:0] waitCnt;
  logic       errHit;

  // ====================
  // wait states
  // ====================
  // loaded in SETUP, runs down during ACCESS
  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      waitCnt <= '0;
    end else if (psel && !penable) begin
      waitCnt <= waitCycles;
    end else if (psel && penable && (waitCnt != '0)) begin
      waitCnt <= waitCnt - 1'b1;
    end
  end

  assign errHit  = &apbReq.paddr[7:2];
  assign pready  = psel & penable & (waitCnt == '0);
  assign pslverr = pready & errHit;
  // erroring reads return zero
  assign prdata  = (pready && !errHit) ? memRdata : '0;

  // erroring writes leave memory alone
  assign memWrite = pready & apbReq.pwrite & ~errHit;

endmodule

// ==== dv/axiApbBridgeTb.sv ====
/* Random AXI traffic against NumSlaves APB memory slaves, checked against a memory model.
   In the mixed phase reads and writes target disjoint windows so read data stays predictable. */
module axiApbBridgeTb;
  localparam int unsigned NumSlaves = 4;
  localparam int unsigned WinBits   = 12;
  localparam int unsigned MemWords  = NumSlaves << (WinBits - 2);
  localparam int          Timeout   = 5000;

  logic                         pclk;
  logic                         preset_n;
  axiPkg::addrReq_t             arReq;
  logic                         arValid;
  logic                         arReady;
  axiPkg::addrReq_t             awReq;
  logic                         awValid;
  logic                         awReady;
  axiPkg::wBeat_t               wBeat;
  logic                         wValid;
  logic                         wReady;
  axiPkg::rBeat_t               rBeat;
  logic                         rValid;
  logic                         rReady;
  axiPkg::bRsp_t                bRsp;
  logic                         bValid;
  logic                         bReady;
  apbPkg::apbReq_t              apbReq;
  logic [NumSlaves-1:0]         psel;
  logic                         penable;
  wire  [NumSlaves-1:0]         pready;
  wire  axiPkg::data_t [NumSlaves-1:0] prdata;
  wire  [NumSlaves-1:0]         pslverr;
  wire  [NumSlaves-1:0]         memWrite;
  logic [1:0]                   waitCycles;
  axiPkg::data_t                memRdata;

  axiPkg::data_t  mem [MemWords];
  axiPkg::data_t  refMem [MemWords];
  axiPkg::rBeat_t expR [$];
  axiPkg::bRsp_t  expB [$];
  axiPkg::prot_t  expRdProt [$];
  axiPkg::prot_t  expWrProt [$];
  logic [31:0]    rngState = 32'd24;
  logic           stallOn = 1'b0;
  axiPkg::id_t    nextId = '0;

  axiApbBridge #(
    .NumSlaves(NumSlaves),
    .WinBits  (WinBits),
    .FifoDepth(4)
  ) dut_i (
    .pclk, .preset_n,
    .arReq, .arValid, .arReady,
    .awReq, .awValid, .awReady,
    .wBeat, .wValid, .wReady,
    .rBeat, .rValid, .rReady,
    .bRsp, .bValid, .bReady,
    .apbReq, .psel, .penable,
    .pready, .prdata, .pslverr
  );

  for (genvar k = 0; k < NumSlaves; k++) begin : slaveGen
    apbMemSlave slave_i (
      .pclk, .preset_n,
      .psel      (psel[k]),
      .penable, .apbReq, .waitCycles, .memRdata,
      .pready    (pready[k]),
      .prdata    (prdata[k]),
      .pslverr   (pslverr[k]),
      .memWrite  (memWrite[k])
    );
  end

  // ====================
  // helpers
  // ====================
  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic int unsigned wordOf(input axiPkg::addr_t a);
    return (a >> 2) % MemWords;
  endfunction

  function automatic axiPkg::data_t fillWord(input axiPkg::addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic axiPkg::data_t mergeStrb(input axiPkg::data_t old,
                                              input axiPkg::data_t newData,
                                              input axiPkg::strb_t strb);
    axiPkg::data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = newData[8*b +: 8];
    end
    return res;
  endfunction

  function automatic axiPkg::addr_t beatAddr(input axiPkg::addr_t addr,
                                             input axiPkg::burst_e burst, input int idx);
    if (burst == axiPkg::FIXED) return addr;
    else return addr + axiPkg::addr_t'(idx * 4);
  endfunction

  function automatic axiPkg::resp_e expectedResp(input axiPkg::addr_t a);
    if (a >= (axiPkg::addr_t'(NumSlaves) << WinBits)) return axiPkg::DECERR;
    else if (&a[7:2]) return axiPkg::SLVERR;
    else return axiPkg::OKAY;
  endfunction

  function automatic logic [NumSlaves-1:0] pselFor(input axiPkg::addr_t a);
    axiPkg::addr_t idx;
    idx = a >> WinBits;
    if (idx < NumSlaves) return NumSlaves'(1) << idx;
    else return '0;
  endfunction

  // sel 0 points past the last window
  function automatic axiPkg::addr_t regionBase(input logic forWrite, input logic [1:0] sel);
    if (sel == 2'd0) return 32'h0001_0000;
    else if (forWrite) return axiPkg::addr_t'(sel[0]) << WinBits;
    else return axiPkg::addr_t'(2 + sel[0]) << WinBits;
  endfunction

  function automatic logic readyOf(input int unsigned ch);
    case (ch)
      0:       return arReady;
      1:       return awReady;
      default: return wReady;
    endcase
  endfunction

  task automatic stopWithFailure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // ====================
  // compare tasks
  // ====================
  task automatic checkRBeat(input axiPkg::rBeat_t got);
    axiPkg::rBeat_t want;
    if (expR.size() == 0) begin
      stopWithFailure("an R beat arrived with no read outstanding");
    end else begin
      want = expR.pop_front();
      if (got !== want) begin
        stopWithFailure($sformatf(
          "FAILED rBeat data/resp/id/last expected %h/%h/%h/%h got %h/%h/%h/%h",
          want.data, want.resp, want.id, want.last, got.data, got.resp, got.id, got.last));
      end
    end
  endtask

  task automatic checkBRsp(input axiPkg::bRsp_t got);
    axiPkg::bRsp_t want;
    if (expB.size() == 0) begin
      stopWithFailure("a B response arrived with no write outstanding");
    end else begin
      want = expB.pop_front();
      if (got !== want) begin
        stopWithFailure($sformatf("FAILED bRsp resp/id expected %h/%h got %h/%h",
                                  want.resp, want.id, got.resp, got.id));
      end
    end
  endtask

  task automatic checkPsel(input logic [NumSlaves-1:0] got, input logic [NumSlaves-1:0] want);
    if (got !== want) begin
      stopWithFailure($sformatf("FAILED psel expected %h got %h at paddr %h",
                                want, got, apbReq.paddr));
    end
  endtask

  task automatic checkPprot(input logic pwrite, input axiPkg::prot_t got);
    axiPkg::prot_t want;
    if ((pwrite && (expWrProt.size() == 0)) || (!pwrite && (expRdProt.size() == 0))) begin
      stopWithFailure("an APB transfer completed with no burst outstanding");
    end else begin
      if (pwrite) begin
        want = expWrProt.pop_front();
      end else begin
        want = expRdProt.pop_front();
      end
      if (got !== want) begin
        stopWithFailure($sformatf("FAILED pprot expected %h got %h at paddr %h",
                                  want, got, apbReq.paddr));
      end
    end
  endtask

  // ====================
  // AXI master side
  // ====================
  // entered and left 2 units after a rising edge
  task automatic waitHandshake(input int unsigned ch, input string name);
    int waitCnt;
    waitCnt = 0;
    @(negedge pclk);
    while (!readyOf(ch)) begin
      waitCnt++;
      if (waitCnt > Timeout) stopWithFailure({"timed out waiting for ", name});
      else @(negedge pclk);
    end
    @(posedge pclk);
    #2;
  endtask

  task automatic issueRead(input axiPkg::addr_t addr, input axiPkg::len_t len,
                           input axiPkg::burst_e burst);
    axiPkg::addrReq_t req;
    axiPkg::rBeat_t   beat;
    axiPkg::addr_t    a;
    logic [31:0]      r;
    r = nextRand();
    req = '{addr: addr, id: nextId, len: len, burst: burst, prot: r[2:0]};
    nextId++;
    for (int i = 0; i <= len; i++) begin
      a = beatAddr(addr, burst, i);
      beat.resp = expectedResp(a);
      beat.data = (beat.resp == axiPkg::OKAY) ? refMem[wordOf(a)] : '0;
      beat.id   = req.id;
      beat.last = (i == len);
      expR.push_back(beat);
      expRdProt.push_back(req.prot);
    end
    arReq   = req;
    arValid = 1'b1;
    waitHandshake(0, "arReady");
    arValid = 1'b0;
  endtask

  task automatic issueWrite(input axiPkg::addr_t addr, input axiPkg::len_t len,
                            input axiPkg::burst_e burst);
    axiPkg::addrReq_t req;
    axiPkg::wBeat_t   beats [$];
    axiPkg::wBeat_t   beat;
    axiPkg::addr_t    a;
    axiPkg::resp_e    resp;
    axiPkg::resp_e    worst;
    logic [31:0]      r;
    r = nextRand();
    req = '{addr: addr, id: nextId, len: len, burst: burst, prot: r[2:0]};
    nextId++;
    worst = axiPkg::OKAY;
    for (int i = 0; i <= len; i++) begin
      a = beatAddr(addr, burst, i);
      beat.data = nextRand();
      r = nextRand();
      beat.strb = r[3:0];
      beats.push_back(beat);
      expWrProt.push_back(req.prot);
      resp = expectedResp(a);
      if (resp == axiPkg::OKAY) begin
        refMem[wordOf(a)] = mergeStrb(refMem[wordOf(a)], beat.data, beat.strb);
      end
      if (resp > worst) worst = resp;
    end
    expB.push_back('{resp: worst, id: req.id});
    awReq   = req;
    awValid = 1'b1;
    waitHandshake(1, "awReady");
    awValid = 1'b0;
    foreach (beats[i]) begin
      wBeat  = beats[i];
      wValid = 1'b1;
      waitHandshake(2, "wReady");
      wValid = 1'b0;
    end
  endtask

  task automatic drain();
    int waitCnt;
    waitCnt = 0;
    while ((expR.size() != 0) || (expB.size() != 0)) begin
      waitCnt++;
      if (waitCnt > Timeout) stopWithFailure("timed out waiting for outstanding R and B");
      else @(posedge pclk);
    end
    @(posedge pclk);
    #2;
  endtask

  // ====================
  // clock, slaves, monitors
  // ====================
  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  assign memRdata = mem[wordOf(apbReq.paddr)];

  always @(posedge pclk) begin
    if (|memWrite) begin
      mem[wordOf(apbReq.paddr)] <= mergeStrb(mem[wordOf(apbReq.paddr)],
                                             apbReq.pwdata, apbReq.pstrb);
    end
  end

  // ready stalls and slave wait states, drawn at the falling edge
  initial begin
    logic [31:0] stallRnd;
    logic        rNext;
    logic        bNext;
    rReady     = 1'b0;
    bReady     = 1'b0;
    waitCycles = '0;
    forever begin
      @(negedge pclk);
      stallRnd = nextRand();
      rNext    = ~stallOn | stallRnd[0];
      bNext    = ~stallOn | stallRnd[1];
      @(posedge pclk);
      #2;
      rReady     = rNext;
      bReady     = bNext;
      waitCycles = stallRnd[5:4];
    end
  end

  always @(negedge pclk) begin
    if (preset_n) begin
      if (rValid && rReady) checkRBeat(rBeat);
      if (bValid && bReady) checkBRsp(bRsp);
      if (|psel) checkPsel(psel, pselFor(apbReq.paddr));
      // a beat ends on pready of its slave, or at once on a decode error
      if (penable && ((psel == '0) || |(psel & pready))) begin
        checkPprot(apbReq.pwrite, apbReq.pprot);
      end
    end
  end

  // ====================
  // test sequence
  // ====================
  initial begin : stimulus
    logic [31:0]    r;
    axiPkg::len_t   len;
    axiPkg::addr_t  off;
    axiPkg::burst_e burst;
    preset_n = 1'b0;
    arReq    = '0;
    arValid  = 1'b0;
    awReq    = '0;
    awValid  = 1'b0;
    wBeat    = '0;
    wValid   = 1'b0;
    for (int i = 0; i < MemWords; i++) begin
      mem[i]    = fillWord(axiPkg::addr_t'(i * 4));
      refMem[i] = mem[i];
    end
    repeat (16) @(posedge pclk);
    #2;
    preset_n = 1'b1;
    @(posedge pclk);
    #2;

    // single beat write, then read back
    issueWrite(32'h0000_1040, 8'd0, axiPkg::INCR);
    drain();
    issueRead(32'h0000_1040, 8'd0, axiPkg::INCR);
    drain();

    // INCR of random length, FIXED on one word, neighbours read back
    r = nextRand();
    len = {4'd0, r[3:0]};
    issueWrite(32'h0000_2100, len, axiPkg::INCR);
    drain();
    issueRead(32'h0000_2100, len, axiPkg::INCR);
    issueWrite(32'h0000_3200, 8'd4, axiPkg::FIXED);
    drain();
    issueRead(32'h0000_3200, 8'd2, axiPkg::FIXED);
    issueRead(32'h0000_31FC, 8'd2, axiPkg::INCR);
    drain();

    // middle beat lands on the error word
    issueWrite(32'h0000_00F8, 8'd2, axiPkg::INCR);
    drain();
    issueRead(32'h0000_00F8, 8'd2, axiPkg::INCR);
    drain();

    // beyond the last window
    issueWrite(32'h0000_4000, 8'd3, axiPkg::INCR);
    issueRead(32'h0002_0000, 8'd2, axiPkg::INCR);
    drain();

    // mixed traffic under R and B stalls
    stallOn = 1'b1;
    repeat (60) begin
      r = nextRand();
      off = axiPkg::addr_t'((r[17:8] % 1008) * 4);
      burst = r[4] ? axiPkg::INCR : axiPkg::FIXED;
      if (r[22]) issueWrite(regionBase(1'b1, r[21:20]) + off, {4'd0, r[3:0]}, burst);
      else issueRead(regionBase(1'b0, r[21:20]) + off, {4'd0, r[3:0]}, burst);
    end
    drain();
    stallOn = 1'b0;

    if ((expR.size() != 0) || (expB.size() != 0)) begin
      stopWithFailure("responses still outstanding at end of test");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== axiApbBridge.f ====
hdl/axiPkg.sv
hdl/apbPkg.sv
hdl/syncFifo.sv
hdl/readPath.sv
hdl/writePath.sv
hdl/apbSequencer.sv
hdl/axiApbBridge.sv
dv/apbMemSlave.sv
dv/axiApbBridgeTb.sv

// ==== Bender.yml ====
package:
  name: axiApbBridge

sources:
  - hdl/axiPkg.sv
  - hdl/apbPkg.sv
  - hdl/syncFifo.sv
  - hdl/readPath.sv
  - hdl/writePath.sv
  - hdl/apbSequencer.sv
  - hdl/axiApbBridge.sv
  - target: test
    files:
      - dv/apbMemSlave.sv
      - dv/axiApbBridgeTb.sv
